//--- riscv_core_macros.svh
`ifndef RISCV_CORE_MACROS_SVH
`define RISCV_CORE_MACROS_SVH

// Data path and register file sizes
`define XLEN        32
`define NUM_REGS    32
`define REG_ADDR_W  5

// Major opcodes of the supported subset
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011

// funct3 codes, SW shares its code with LW
`define F3_ADD      3'b000
`define F3_SLT      3'b010
`define F3_XOR      3'b100
`define F3_OR       3'b110
`define F3_AND      3'b111
`define F3_LW       3'b010

`define F7_SUB      7'b0100000

// ADDI x0,x0,0
`define NOP_WORD    32'h0000_0013

`endif

//--- riscv_core_pkg.sv
`include "riscv_core_macros.svh"

package riscv_core_pkg;

    // Data word, also used for byte addresses
    typedef logic [`XLEN-1:0] word_t;

    // Register index
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // ALU operation, PASS_B doubles as the bubble encoding
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_t;

endpackage

//--- pipe_stage_if.sv
`timescale 1ns/1ps

interface pipe_stage_if;

    // Destination register and its write enable
    riscv_core_pkg::reg_addr_t rd;
    logic                      rd_we;

    // Source registers, kept for forwarding compares
    riscv_core_pkg::reg_addr_t rs1;
    riscv_core_pkg::reg_addr_t rs2;
    logic                      rs1_used;
    logic                      rs2_used;

    // Operands, or result and store data after execute
    riscv_core_pkg::word_t     op1;
    riscv_core_pkg::word_t     op2;
    riscv_core_pkg::word_t     imm;

    riscv_core_pkg::alu_op_t   alu_op;
    logic                      is_load;
    logic                      is_store;

    modport producer (
        output rd, rd_we, rs1, rs2, rs1_used, rs2_used,
        output op1, op2, imm, alu_op, is_load, is_store
    );

    modport consumer (
        input rd, rd_we, rs1, rs2, rs1_used, rs2_used,
        input op1, op2, imm, alu_op, is_load, is_store
    );

endinterface

//--- fetch_stage.sv
`timescale 1ns/1ps
`include "riscv_core_macros.svh"

module fetch_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,
    input  riscv_core_pkg::word_t instr,
    output riscv_core_pkg::word_t pc,
    output riscv_core_pkg::word_t dec_instr,
    output riscv_core_pkg::word_t dec_pc
);

    // pc of the word now arriving on instr
    riscv_core_pkg::word_t fetch_pc;
    riscv_core_pkg::word_t held_instr;
    riscv_core_pkg::word_t held_pc;
    // Low until the first real fetch returns
    logic                  fetch_valid;
    logic                  use_held;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc          <= '0;
            fetch_valid <= 1'b0;
            use_held    <= 1'b0;
        end else begin
            if (!stall) begin
                pc <= pc + riscv_core_pkg::word_t'(4);
            end
            fetch_valid <= 1'b1;
            use_held    <= stall;
        end
    end

    // Copy of the word under decode, replayed for one cycle after a stall
    always_ff @(posedge clk) begin
        fetch_pc   <= pc;
        held_instr <= dec_instr;
        held_pc    <= dec_pc;
    end

    assign dec_instr = !fetch_valid ? `NOP_WORD : (use_held ? held_instr : instr);
    assign dec_pc    = use_held ? held_pc : fetch_pc;

    pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00 && dec_pc[1:0] == 2'b00);

endmodule

//--- decode_stage.sv
`timescale 1ns/1ps
`include "riscv_core_macros.svh"

module decode_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  riscv_core_pkg::word_t     dec_instr,
    input  riscv_core_pkg::word_t     rs1_value,
    input  riscv_core_pkg::word_t     rs2_value,
    output riscv_core_pkg::reg_addr_t rs1_addr,
    output riscv_core_pkg::reg_addr_t rs2_addr,
    output logic                      stall,
    pipe_stage_if.producer            id_ex
);

    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    riscv_core_pkg::word_t   imm_i;
    riscv_core_pkg::word_t   imm_s;

    logic                    dec_valid;
    logic                    dec_rd_we;
    logic                    dec_rs1_used;
    logic                    dec_rs2_used;
    logic                    dec_load;
    logic                    dec_store;
    riscv_core_pkg::alu_op_t dec_alu_op;
    riscv_core_pkg::word_t   dec_imm;

    assign opcode   = dec_instr[6:0];
    assign funct3   = dec_instr[14:12];
    assign funct7   = dec_instr[31:25];
    assign rs1_addr = dec_instr[19:15];
    assign rs2_addr = dec_instr[24:20];

    assign imm_i = {{20{dec_instr[31]}}, dec_instr[31:20]};
    assign imm_s = {{20{dec_instr[31]}}, dec_instr[31:25], dec_instr[11:7]};

    always_comb begin
        dec_valid    = 1'b0;
        dec_rd_we    = 1'b0;
        dec_rs1_used = 1'b0;
        dec_rs2_used = 1'b0;
        dec_load     = 1'b0;
        dec_store    = 1'b0;
        dec_alu_op   = riscv_core_pkg::ALU_ADD;
        dec_imm      = imm_i;
        case (opcode)
            `OPC_OP: begin
                dec_valid = (funct7 == 7'b0) ||
                            (funct7 == `F7_SUB && funct3 == `F3_ADD);
                case (funct3)
                    `F3_ADD: dec_alu_op = (funct7 == `F7_SUB) ? riscv_core_pkg::ALU_SUB
                                                              : riscv_core_pkg::ALU_ADD;
                    `F3_SLT: dec_alu_op = riscv_core_pkg::ALU_SLT;
                    `F3_XOR: dec_alu_op = riscv_core_pkg::ALU_XOR;
                    `F3_OR:  dec_alu_op = riscv_core_pkg::ALU_OR;
                    `F3_AND: dec_alu_op = riscv_core_pkg::ALU_AND;
                    default: dec_valid  = 1'b0;
                endcase
                dec_rd_we    = 1'b1;
                dec_rs1_used = 1'b1;
                dec_rs2_used = 1'b1;
            end
            // ADDI only
            `OPC_OP_IMM: begin
                dec_valid    = (funct3 == `F3_ADD);
                dec_rd_we    = 1'b1;
                dec_rs1_used = 1'b1;
            end
            `OPC_LOAD: begin
                dec_valid    = (funct3 == `F3_LW);
                dec_rd_we    = 1'b1;
                dec_rs1_used = 1'b1;
                dec_load     = 1'b1;
            end
            `OPC_STORE: begin
                dec_valid    = (funct3 == `F3_LW);
                dec_rs1_used = 1'b1;
                dec_rs2_used = 1'b1;
                dec_store    = 1'b1;
                dec_imm      = imm_s;
            end
            default: dec_valid = 1'b0;
        endcase
    end

    // Load in execute whose result is needed here
    assign stall = dec_valid && id_ex.is_load && id_ex.rd != '0 &&
                   ((dec_rs1_used && rs1_addr == id_ex.rd) ||
                    (dec_rs2_used && rs2_addr == id_ex.rd));

    always_ff @(posedge clk) begin
        if (!rst_n || stall || !dec_valid) begin
            id_ex.rd       <= '0;
            id_ex.rd_we    <= 1'b0;
            id_ex.rs1_used <= 1'b0;
            id_ex.rs2_used <= 1'b0;
            id_ex.is_load  <= 1'b0;
            id_ex.is_store <= 1'b0;
            id_ex.alu_op   <= riscv_core_pkg::ALU_PASS_B;
        end else begin
            id_ex.rd       <= dec_instr[11:7];
            id_ex.rd_we    <= dec_rd_we;
            id_ex.rs1_used <= dec_rs1_used;
            id_ex.rs2_used <= dec_rs2_used;
            id_ex.is_load  <= dec_load;
            id_ex.is_store <= dec_store;
            id_ex.alu_op   <= dec_alu_op;
        end
    end

    always_ff @(posedge clk) begin
        id_ex.rs1 <= rs1_addr;
        id_ex.rs2 <= rs2_addr;
        id_ex.op1 <= rs1_value;
        id_ex.op2 <= rs2_value;
        id_ex.imm <= dec_imm;
    end

    // The bubble after a stall clears the load, so the stall cannot repeat
    stall_single: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> !stall);

endmodule

//--- register_file.sv
`timescale 1ns/1ps
`include "riscv_core_macros.svh"

module register_file (
    input  logic                      clk,
    input  riscv_core_pkg::reg_addr_t rs1_addr,
    input  riscv_core_pkg::reg_addr_t rs2_addr,
    input  riscv_core_pkg::reg_addr_t wb_rd,
    input  logic                      wb_we,
    input  riscv_core_pkg::word_t     wb_value,
    output riscv_core_pkg::word_t     rs1_value,
    output riscv_core_pkg::word_t     rs2_value
);

    riscv_core_pkg::word_t regs [`NUM_REGS];

    // x0 reads zero, a same-cycle write is passed straight through
    function automatic riscv_core_pkg::word_t read_port(
        input riscv_core_pkg::reg_addr_t addr
    );
        if (addr == '0) begin
            return '0;
        end else if (wb_we && wb_rd == addr) begin
            return wb_value;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_value;
        end
    end

    always_comb begin
        rs1_value = read_port(rs1_addr);
        rs2_value = read_port(rs2_addr);
    end

endmodule

//--- execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  riscv_core_pkg::reg_addr_t wb_rd,
    input  logic                      wb_we,
    input  riscv_core_pkg::word_t     wb_value,
    pipe_stage_if.consumer            id_ex,
    pipe_stage_if.producer            ex_mem
);

    riscv_core_pkg::word_t fwd_a;
    riscv_core_pkg::word_t fwd_b;
    riscv_core_pkg::word_t alu_b;
    riscv_core_pkg::word_t alu_result;

    // EX/MEM result first, then writeback, then the value read in decode.
    // Loads in EX/MEM are skipped, the stall keeps them out of reach.
    function automatic riscv_core_pkg::word_t forward(
        input riscv_core_pkg::reg_addr_t src,
        input logic                      used,
        input riscv_core_pkg::word_t     id_value
    );
        if (used && src != '0) begin
            if (ex_mem.rd_we && !ex_mem.is_load && ex_mem.rd == src) begin
                return ex_mem.op1;
            end
            if (wb_we && wb_rd == src) begin
                return wb_value;
            end
        end
        return id_value;
    endfunction

    always_comb begin
        fwd_a = forward(id_ex.rs1, id_ex.rs1_used, id_ex.op1);
        fwd_b = forward(id_ex.rs2, id_ex.rs2_used, id_ex.op2);
    end

    // Register operand for R-type, immediate otherwise
    assign alu_b = (id_ex.rs2_used && !id_ex.is_store) ? fwd_b : id_ex.imm;

    always_comb begin
        case (id_ex.alu_op)
            riscv_core_pkg::ALU_ADD: alu_result = fwd_a + alu_b;
            riscv_core_pkg::ALU_SUB: alu_result = fwd_a - alu_b;
            riscv_core_pkg::ALU_AND: alu_result = fwd_a & alu_b;
            riscv_core_pkg::ALU_OR:  alu_result = fwd_a | alu_b;
            riscv_core_pkg::ALU_XOR: alu_result = fwd_a ^ alu_b;
            riscv_core_pkg::ALU_SLT: begin
                alu_result = {31'b0, $signed(fwd_a) < $signed(alu_b)};
            end
            default: alu_result = alu_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem.rd       <= '0;
            ex_mem.rd_we    <= 1'b0;
            ex_mem.is_load  <= 1'b0;
            ex_mem.is_store <= 1'b0;
        end else begin
            ex_mem.rd       <= id_ex.rd;
            ex_mem.rd_we    <= id_ex.rd_we;
            ex_mem.is_load  <= id_ex.is_load;
            ex_mem.is_store <= id_ex.is_store;
        end
    end

    // Result or address, and the store data
    always_ff @(posedge clk) begin
        ex_mem.op1 <= alu_result;
        ex_mem.op2 <= fwd_b;
    end

    // Fields the memory stage has no use for
    assign ex_mem.rs1      = '0;
    assign ex_mem.rs2      = '0;
    assign ex_mem.rs1_used = 1'b0;
    assign ex_mem.rs2_used = 1'b0;
    assign ex_mem.imm      = '0;
    assign ex_mem.alu_op   = riscv_core_pkg::ALU_ADD;

    load_store_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(id_ex.is_load && id_ex.is_store));

endmodule

//--- memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  riscv_core_pkg::word_t     read_data,
    pipe_stage_if.consumer            ex_mem,
    output logic                      mem_rd_en,
    output logic                      mem_wr_en,
    output riscv_core_pkg::word_t     read_addr,
    output riscv_core_pkg::word_t     write_addr,
    output riscv_core_pkg::word_t     wr_data,
    output riscv_core_pkg::reg_addr_t wb_rd,
    output logic                      wb_we,
    output riscv_core_pkg::word_t     wb_value
);

    logic                  wb_load;
    riscv_core_pkg::word_t wb_result;

    // Data memory strobes come straight from EX/MEM
    assign mem_rd_en  = ex_mem.is_load;
    assign read_addr  = ex_mem.op1;
    assign mem_wr_en  = ex_mem.is_store;
    assign write_addr = ex_mem.op1;
    assign wr_data    = ex_mem.op2;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_rd   <= '0;
            wb_we   <= 1'b0;
            wb_load <= 1'b0;
        end else begin
            wb_rd   <= ex_mem.rd;
            wb_we   <= ex_mem.rd_we;
            wb_load <= ex_mem.is_load;
        end
    end

    always_ff @(posedge clk) begin
        wb_result <= ex_mem.op1;
    end

    // Load data returns one cycle after the read strobe
    assign wb_value = wb_load ? read_data : wb_result;

endmodule

//--- riscv_core.sv
`timescale 1ns/1ps

module riscv_core (
    input  logic                  clk,
    input  logic                  rst_n,
    input  riscv_core_pkg::word_t instr,
    input  riscv_core_pkg::word_t read_data,
    output riscv_core_pkg::word_t pc,
    output logic                  mem_rd_en,
    output riscv_core_pkg::word_t read_addr,
    output logic                  mem_wr_en,
    output riscv_core_pkg::word_t write_addr,
    output riscv_core_pkg::word_t wr_data
);

    logic                      stall;
    riscv_core_pkg::word_t     dec_instr;
    riscv_core_pkg::reg_addr_t rs1_addr;
    riscv_core_pkg::reg_addr_t rs2_addr;
    riscv_core_pkg::word_t     rs1_value;
    riscv_core_pkg::word_t     rs2_value;

    // Writeback, shared by the register file and forwarding
    riscv_core_pkg::reg_addr_t wb_rd;
    logic                      wb_we;
    riscv_core_pkg::word_t     wb_value;

    pipe_stage_if id_ex ();
    pipe_stage_if ex_mem ();

    fetch_stage u_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .instr     (instr),
        .pc        (pc),
        .dec_instr (dec_instr),
        .dec_pc    ()
    );

    decode_stage u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_instr (dec_instr),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .stall     (stall),
        .id_ex     (id_ex.producer)
    );

    register_file u_regs (
        .clk       (clk),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .wb_rd     (wb_rd),
        .wb_we     (wb_we),
        .wb_value  (wb_value),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value)
    );

    execute_stage u_execute (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_rd    (wb_rd),
        .wb_we    (wb_we),
        .wb_value (wb_value),
        .id_ex    (id_ex.consumer),
        .ex_mem   (ex_mem.producer)
    );

    memory_stage u_memory (
        .clk        (clk),
        .rst_n      (rst_n),
        .read_data  (read_data),
        .ex_mem     (ex_mem.consumer),
        .mem_rd_en  (mem_rd_en),
        .mem_wr_en  (mem_wr_en),
        .read_addr  (read_addr),
        .write_addr (write_addr),
        .wr_data    (wr_data),
        .wb_rd      (wb_rd),
        .wb_we      (wb_we),
        .wb_value   (wb_value)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 20 ns period
    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
    end

    always #10 clk = ~clk;

    // Reset held over two rising edges
    initial begin
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- tb_riscv_core.sv
`timescale 1ns/1ps
`include "riscv_core_macros.svh"

module tb_riscv_core;

    typedef struct {
        logic [31:0] instr;
        logic        is_store;
        logic [31:0] addr;
        logic [31:0] data;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic        mem_rd_en;
    logic        mem_wr_en;
    logic [31:0] instr;
    logic [31:0] read_data;
    logic [31:0] pc;
    logic [31:0] read_addr;
    logic [31:0] write_addr;
    logic [31:0] wr_data;

    logic [31:0] rom [256];
    logic [31:0] ram [256];
    row_t        rows [$];
    row_t        stores [$];
    logic [31:0] load_addrs [$];

    // Architectural model, only used while the table is built
    logic [31:0] model_regs [32];
    logic [31:0] model_mem [256];
    logic [31:0] lcg_state;
    int          last_load_rd;
    int          exp_stalls;

    int          store_idx;
    int          load_idx;
    int          pc_holds;
    int          value_errors;
    int          other_errors;
    logic        running;
    logic [31:0] last_pc;

    tb_clock_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    riscv_core dut (.*);

    function automatic logic [31:0] fill_word(input int idx);
        logic [31:0] addr;
        addr = 32'(idx) << 2;
        return addr ^ 32'hA5A5_5A5A;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic push_row(input logic [31:0] word, input logic is_store,
                            input logic [31:0] addr, input logic [31:0] data);
        row_t row;
        row.instr    = word;
        row.is_store = is_store;
        row.addr     = addr;
        row.data     = data;
        rows.push_back(row);
    endtask

    // A source that matches the load just before costs one held cycle
    task automatic predict_stall(input int rs1, input int rs2, input logic uses_rs2);
        if (last_load_rd != 0 && (rs1 == last_load_rd || (uses_rs2 && rs2 == last_load_rd))) begin
            exp_stalls++;
        end
    endtask

    task automatic alu_row(input logic [6:0] f7, input logic [2:0] f3,
                           input int rd, input int rs1, input int rs2);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        a = model_regs[rs1];
        b = model_regs[rs2];
        case (f3)
            `F3_ADD: res = (f7 == `F7_SUB) ? a - b : a + b;
            `F3_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `F3_XOR: res = a ^ b;
            `F3_OR:  res = a | b;
            default: res = a & b;
        endcase
        predict_stall(rs1, rs2, 1'b1);
        if (rd != 0) begin
            model_regs[rd] = res;
        end
        last_load_rd = 0;
        push_row({f7, 5'(rs2), 5'(rs1), f3, 5'(rd), `OPC_OP}, 1'b0, '0, '0);
    endtask

    task automatic addi_row(input int rd, input int rs1, input logic [11:0] imm);
        predict_stall(rs1, 0, 1'b0);
        if (rd != 0) begin
            model_regs[rd] = model_regs[rs1] + sext12(imm);
        end
        last_load_rd = 0;
        push_row({imm, 5'(rs1), `F3_ADD, 5'(rd), `OPC_OP_IMM}, 1'b0, '0, '0);
    endtask

    task automatic load_row(input int rd, input int rs1, input logic [11:0] imm);
        logic [31:0] addr;
        addr = model_regs[rs1] + sext12(imm);
        predict_stall(rs1, 0, 1'b0);
        if (rd != 0) begin
            model_regs[rd] = model_mem[addr[9:2]];
        end
        last_load_rd = rd;
        load_addrs.push_back(addr);
        push_row({imm, 5'(rs1), `F3_LW, 5'(rd), `OPC_LOAD}, 1'b0, '0, '0);
    endtask

    task automatic store_row(input int rs2, input int rs1, input logic [11:0] imm);
        logic [31:0] addr;
        addr = model_regs[rs1] + sext12(imm);
        predict_stall(rs1, rs2, 1'b1);
        model_mem[addr[9:2]] = model_regs[rs2];
        last_load_rd = 0;
        push_row({imm[11:5], 5'(rs2), 5'(rs1), `F3_LW, imm[4:0], `OPC_STORE}, 1'b1,
                 addr, model_regs[rs2]);
    endtask

    // Instruction ROM and data RAM, both answer one cycle later
    always @(posedge clk) begin
        instr <= rom[pc[9:2]];
        if (mem_rd_en) begin
            read_data <= ram[read_addr[9:2]];
        end
        if (mem_wr_en) begin
            ram[write_addr[9:2]] <= wr_data;
        end
    end

    // Reset values, then a 4 byte step or a one cycle hold
    always @(negedge clk) begin
        if (!rst_n || !running) begin
            assert (pc == '0 && !mem_rd_en && !mem_wr_en) else begin
                value_errors++;
                $display("Fail at %0t: pc %h rd_en %b wr_en %b around reset",
                         $time, pc, mem_rd_en, mem_wr_en);
            end
            running = rst_n;
        end else if (pc == last_pc) begin
            pc_holds++;
        end else begin
            assert (pc == last_pc + 32'd4) else begin
                value_errors++;
                $display("Fail at %0t: pc %h after %h", $time, pc, last_pc);
            end
        end
        last_pc = pc;
    end

    // Stores in program order
    always @(negedge clk) begin
        if (rst_n && mem_wr_en) begin
            if (store_idx >= stores.size()) begin
                other_errors++;
                $display("A store to %h came after all expected stores", write_addr);
            end else begin
                assert (write_addr == stores[store_idx].addr &&
                        wr_data == stores[store_idx].data) else begin
                    value_errors++;
                    $display("Fail at %0t: store %0d wrote %h to %h, expected %h to %h",
                             $time, store_idx, wr_data, write_addr,
                             stores[store_idx].data, stores[store_idx].addr);
                end
                store_idx++;
            end
        end
    end

    // Load addresses in program order
    always @(negedge clk) begin
        if (rst_n && mem_rd_en) begin
            if (load_idx >= load_addrs.size()) begin
                other_errors++;
                $display("A load from %h came after all expected loads", read_addr);
            end else begin
                assert (read_addr == load_addrs[load_idx]) else begin
                    value_errors++;
                    $display("Fail at %0t: load %0d read %h, expected %h",
                             $time, load_idx, read_addr, load_addrs[load_idx]);
                end
                load_idx++;
            end
        end
    end

    initial begin : stimulus
        logic [11:0] imm;
        int          cycle_limit;
        int          cycle_count;
        instr        <= `NOP_WORD;
        read_data    <= '0;
        value_errors = 0;
        other_errors = 0;
        store_idx    = 0;
        load_idx     = 0;
        pc_holds     = 0;
        running      = 1'b0;
        cycle_count  = 0;
        lcg_state    = 32'd42;
        last_load_rd = 0;
        exp_stalls   = 0;
        for (int i = 0; i < 256; i++) begin
            rom[i]       = `NOP_WORD;
            ram[i]       = fill_word(i);
            model_mem[i] = fill_word(i);
        end
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end

        // Dependent ALU chain, every result stored
        addi_row(1, 0, 12'd256);
        addi_row(2, 0, 12'd100);
        addi_row(3, 2, 12'hFF9);
        store_row(3, 1, 12'd0);
        alu_row(7'b0, `F3_ADD, 4, 3, 2);
        store_row(4, 1, 12'd4);
        alu_row(`F7_SUB, `F3_ADD, 5, 2, 4);
        store_row(5, 1, 12'd8);
        alu_row(7'b0, `F3_AND, 6, 5, 4);
        store_row(6, 1, 12'd12);
        alu_row(7'b0, `F3_OR, 7, 6, 5);
        store_row(7, 1, 12'd16);
        alu_row(7'b0, `F3_XOR, 8, 7, 6);
        store_row(8, 1, 12'd20);
        alu_row(7'b0, `F3_SLT, 9, 5, 2);
        store_row(9, 1, 12'd24);
        alu_row(7'b0, `F3_SLT, 10, 2, 5);
        store_row(10, 1, 12'd28);
        // Both operands at distance one, sum wraps
        addi_row(11, 0, 12'hFFF);
        alu_row(7'b0, `F3_ADD, 12, 11, 11);
        alu_row(`F7_SUB, `F3_ADD, 13, 12, 11);
        store_row(12, 1, 12'd32);
        store_row(13, 1, 12'd36);
        // Load-use on an ALU operand and on store data
        addi_row(16, 0, 12'd1234);
        store_row(16, 1, 12'd64);
        load_row(17, 1, 12'd64);
        alu_row(7'b0, `F3_ADD, 18, 17, 16);
        store_row(18, 1, 12'd68);
        load_row(19, 1, 12'd68);
        store_row(19, 1, 12'd72);
        // x0 stays zero
        addi_row(0, 0, 12'd55);
        store_row(0, 1, 12'd80);
        // Random immediate chain
        for (int i = 0; i < 8; i++) begin
            lcg_state = next_random(lcg_state);
            imm       = lcg_state[27:16];
            addi_row(21, (i == 0) ? 0 : 21, imm);
        end
        store_row(21, 1, 12'd84);

        foreach (rows[i]) begin
            rom[i] = rows[i].instr;
            if (rows[i].is_store) begin
                stores.push_back(rows[i]);
            end
        end

        cycle_limit = 2 * rows.size() + 20;
        while (store_idx < stores.size() && cycle_count <= cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        if (store_idx < stores.size()) begin
            other_errors++;
            $display("Timeout after %0d cycles with %0d of %0d stores seen",
                     cycle_count, store_idx, stores.size());
        end
        assert (pc_holds == exp_stalls) else begin
            value_errors++;
            $display("Fail at %0t: pc held %0d cycles, expected %0d",
                     $time, pc_holds, exp_stalls);
        end
        assert (load_idx == load_addrs.size()) else begin
            other_errors++;
            $display("Saw %0d loads, expected %0d", load_idx, load_addrs.size());
        end
        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- riscv_core.f
+incdir+.
riscv_core_pkg.sv
pipe_stage_if.sv
fetch_stage.sv
decode_stage.sv
register_file.sv
execute_stage.sv
memory_stage.sv
riscv_core.sv
tb_clock_gen.sv
tb_riscv_core.sv

//--- Makefile
TOP := tb_riscv_core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f riscv_core.f --top-module $(TOP) -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "Verification passed" sim.log

lint:
	verilator --lint-only -Wall --timing -f riscv_core.f --top-module riscv_core

clean:
	rm -rf obj_dir sim.log
